// File: common/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ------------------------------------------------------------
// Core-wide constants
// ------------------------------------------------------------

// Data and address width
`define CORE_XLEN 32

// Integer register count
`define CORE_REGS 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif

// File: common/isa_pkg.sv
package isa_pkg;

    // ------------------------------------------------------------
    // Major opcodes of the supported RV32I subset
    // ------------------------------------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b011_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011
    } opcode_e;

    // ALU operations, PASS_B forwards operand B untouched (LUI)
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // Branch conditions, JUMP is taken unconditionally
    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU,
        BR_JUMP
    } branch_e;

endpackage

// File: common/pipe_pkg.sv
`include "core_defines.svh"

package pipe_pkg;

    import isa_pkg::*;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [4:0]            reg_idx_t;

    // ------------------------------------------------------------
    // Stage records
    // ------------------------------------------------------------
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        alu_op_e  alu_op;
        branch_e  branch;
        logic     b_is_imm;
        logic     a_is_pc;
        logic     is_load;
        logic     is_store;
        logic     is_jalr;
        logic     writes_rd;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    result;
        word_t    store_data;
        logic     is_load;
        logic     is_store;
        logic     writes_rd;
        reg_idx_t rd;
    } ex_mem_t;

    // Register write, also used for the forwarding paths
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // Shared memory bus request
    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

// File: decode/instr_decoder.sv
module instr_decoder
    import pipe_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  if_id_t    if_id,
    input  redirect_t redirect,
    output reg_idx_t  rs1_idx,
    output reg_idx_t  rs2_idx,
    input  word_t     rs1_data,
    input  word_t     rs2_data,
    output logic      hazard_stall,
    output id_ex_t    id_ex
);

    word_t   instr;
    opcode_e opcode;
    logic    [2:0] funct3;
    logic    use_rs1;
    logic    use_rs2;
    id_ex_t  dec;

    assign instr   = if_id.instr;
    assign opcode  = opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic branch_e branch_from_funct3(input logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            3'b110:  return BR_LTU;
            3'b111:  return BR_GEU;
            default: return BR_NONE;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Field decode and immediate generation
    // ------------------------------------------------------------
    always_comb
    begin
        dec          = '0;
        dec.valid    = if_id.valid;
        dec.pc       = if_id.pc;
        dec.rs1      = rs1_idx;
        dec.rs2      = rs2_idx;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.rd       = instr[11:7];
        dec.alu_op   = ALU_ADD;
        dec.branch   = BR_NONE;
        use_rs1      = 1'b0;
        use_rs2      = 1'b0;

        case (opcode)
            OPC_OP:
            begin
                dec.alu_op    = alu_from_funct3(funct3, instr[30]);
                dec.writes_rd = 1'b1;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
            end
            OPC_OP_IMM:
            begin
                // Only the shift-right immediate uses bit 30
                dec.alu_op    = alu_from_funct3(funct3, funct3 == 3'b101 && instr[30]);
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.b_is_imm  = 1'b1;
                dec.writes_rd = 1'b1;
                use_rs1       = 1'b1;
            end
            OPC_LUI, OPC_AUIPC:
            begin
                dec.alu_op    = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
                dec.a_is_pc   = (opcode == OPC_AUIPC);
                dec.imm       = {instr[31:12], 12'b0};
                dec.b_is_imm  = 1'b1;
                dec.writes_rd = 1'b1;
            end
            OPC_JAL:
            begin
                dec.imm       = {{11{instr[31]}}, instr[31], instr[19:12],
                                 instr[20], instr[30:21], 1'b0};
                dec.branch    = BR_JUMP;
                dec.writes_rd = 1'b1;
            end
            OPC_JALR:
            begin
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.branch    = BR_JUMP;
                dec.is_jalr   = 1'b1;
                dec.writes_rd = 1'b1;
                use_rs1       = 1'b1;
            end
            OPC_BRANCH:
            begin
                dec.imm    = {{19{instr[31]}}, instr[31], instr[7],
                              instr[30:25], instr[11:8], 1'b0};
                dec.branch = branch_from_funct3(funct3);
                use_rs1    = 1'b1;
                use_rs2    = 1'b1;
            end
            OPC_LOAD:
            begin
                dec.imm       = {{20{instr[31]}}, instr[31:20]};
                dec.b_is_imm  = 1'b1;
                dec.is_load   = 1'b1;
                dec.writes_rd = 1'b1;
                use_rs1       = 1'b1;
            end
            OPC_STORE:
            begin
                dec.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dec.b_is_imm = 1'b1;
                dec.is_store = 1'b1;
                use_rs1      = 1'b1;
                use_rs2      = 1'b1;
            end
            default:
                dec.valid = 1'b0;
        endcase

        // x0 is never a destination
        if (dec.rd == '0)
            dec.writes_rd = 1'b0;
    end

    // Load-use hazard against the load now in execute
    assign hazard_stall = dec.valid && id_ex.valid && id_ex.is_load && id_ex.writes_rd &&
                          ((use_rs1 && rs1_idx == id_ex.rd) ||
                           (use_rs2 && rs2_idx == id_ex.rd));

    // ------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            id_ex.valid <= 1'b0;
        else if (redirect.valid || hazard_stall)
            id_ex.valid <= 1'b0;
        else
            id_ex <= dec;
    end

endmodule

// File: execute/execute_unit.sv
module execute_unit
    import pipe_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  id_ex_t    id_ex,
    input  wb_t       mem_fwd,
    input  wb_t       wb_fwd,
    output redirect_t redirect,
    output ex_mem_t   ex_mem
);

    word_t rs1_val;
    word_t rs2_val;
    word_t op_a;
    word_t op_b;
    word_t alu_out;
    word_t result;
    word_t target_sum;
    logic  taken;

    // Youngest producer wins, x0 never forwards
    function automatic word_t forward(input reg_idx_t idx, input word_t reg_val);
        if (idx != '0 && mem_fwd.valid && mem_fwd.rd == idx)
            return mem_fwd.data;
        else if (idx != '0 && wb_fwd.valid && wb_fwd.rd == idx)
            return wb_fwd.data;
        else
            return reg_val;
    endfunction

    assign rs1_val = forward(id_ex.rs1, id_ex.rs1_data);
    assign rs2_val = forward(id_ex.rs2, id_ex.rs2_data);
    assign op_a    = id_ex.a_is_pc ? id_ex.pc : rs1_val;
    assign op_b    = id_ex.b_is_imm ? id_ex.imm : rs2_val;

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------
    always_comb
    begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << op_b[4:0];
            ALU_SLT:    alu_out = word_t'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_out = word_t'(op_a < op_b);
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> op_b[4:0];
            ALU_SRA:    alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // Jumps write the link address
    assign result = (id_ex.branch == BR_JUMP) ? id_ex.pc + word_t'(4) : alu_out;

    // ------------------------------------------------------------
    // Branch and jump resolution
    // ------------------------------------------------------------
    always_comb
    begin
        case (id_ex.branch)
            BR_EQ:   taken = (rs1_val == rs2_val);
            BR_NE:   taken = (rs1_val != rs2_val);
            BR_LT:   taken = ($signed(rs1_val) < $signed(rs2_val));
            BR_GE:   taken = ($signed(rs1_val) >= $signed(rs2_val));
            BR_LTU:  taken = (rs1_val < rs2_val);
            BR_GEU:  taken = (rs1_val >= rs2_val);
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign target_sum = (id_ex.is_jalr ? rs1_val : id_ex.pc) + id_ex.imm;

    always_comb
    begin
        redirect.valid  = id_ex.valid && taken;
        redirect.target = {target_sum[31:1], target_sum[0] & ~id_ex.is_jalr};
    end

    // ------------------------------------------------------------
    // EX/MEM register
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            ex_mem.valid <= 1'b0;
        else
            ex_mem.valid <= id_ex.valid;
        ex_mem.result     <= result;
        ex_mem.store_data <= rs2_val;
        ex_mem.is_load    <= id_ex.is_load;
        ex_mem.is_store   <= id_ex.is_store;
        ex_mem.writes_rd  <= id_ex.writes_rd;
        ex_mem.rd         <= id_ex.rd;
    end

endmodule

// File: rtl/fetch_control.sv
`include "core_defines.svh"

module fetch_control
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      fetch_grant,
    input  word_t     fetch_word,
    input  logic      hazard_stall,
    input  redirect_t redirect,
    output word_t     fetch_addr,
    output logic      fetch_valid,
    output if_id_t    if_id
);

    word_t pc;

    assign fetch_addr = pc;

    // No request while decode is stalled, unless a redirect overrides it
    assign fetch_valid = !reset && (!hazard_stall || redirect.valid);

    // ------------------------------------------------------------
    // PC and IF/ID register
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc          <= `CORE_RESET_PC;
            if_id.valid <= 1'b0;
            if_id.instr <= `CORE_NOP;
        end
        else if (redirect.valid)
        begin
            // Squash the instruction fetched this cycle
            pc          <= redirect.target;
            if_id.valid <= 1'b0;
            if_id.instr <= `CORE_NOP;
        end
        else if (fetch_grant)
        begin
            pc          <= pc + word_t'(4);
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.instr <= fetch_word;
        end
        else if (!hazard_stall)
        begin
            // Bus lost to a data access, retry the same PC
            if_id.valid <= 1'b0;
            if_id.instr <= `CORE_NOP;
        end
    end

endmodule

// File: rtl/register_file.sv
`include "core_defines.svh"

module register_file
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  wb_t      wb
);

    word_t regs [`CORE_REGS];

    // Write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (wb.valid && wb.rd == idx)
            return wb.data;
        else
            return regs[idx];
    endfunction

    assign rs1_data = read_port(rs1_idx);
    assign rs2_data = read_port(rs2_idx);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CORE_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb.valid && wb.rd != '0)
            regs[wb.rd] <= wb.data;
    end

endmodule

// File: rtl/memory_stage.sv
module memory_stage
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  ex_mem_t  ex_mem,
    input  word_t    fetch_addr,
    input  logic     fetch_valid,
    output logic     fetch_grant,
    output word_t    fetch_word,
    output mem_req_t mem_req,
    input  word_t    mem_rdata,
    output wb_t      mem_fwd,
    output wb_t      wb
);

    logic data_access;

    // ------------------------------------------------------------
    // Bus arbiter, data access has priority over fetch
    // ------------------------------------------------------------
    assign data_access = ex_mem.valid && (ex_mem.is_load || ex_mem.is_store);
    assign fetch_grant = fetch_valid && !data_access;
    assign fetch_word  = mem_rdata;

    always_comb
    begin
        mem_req.valid = data_access || fetch_valid;
        mem_req.write = data_access && ex_mem.is_store;
        mem_req.addr  = data_access ? ex_mem.result : fetch_addr;
        mem_req.wdata = ex_mem.store_data;
    end

    // MEM result, load data arrives in the same cycle
    always_comb
    begin
        mem_fwd.valid = ex_mem.valid && ex_mem.writes_rd;
        mem_fwd.rd    = ex_mem.rd;
        mem_fwd.data  = ex_mem.is_load ? mem_rdata : ex_mem.result;
    end

    // ------------------------------------------------------------
    // MEM/WB register
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            wb.valid <= 1'b0;
        else
            wb.valid <= mem_fwd.valid;
        wb.rd   <= mem_fwd.rd;
        wb.data <= mem_fwd.data;
    end

endmodule

// File: rtl/rv_core.sv
module rv_core
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    output mem_req_t mem_req,
    input  word_t    mem_rdata
);

    // ------------------------------------------------------------
    // Inter-stage wiring
    // ------------------------------------------------------------
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       mem_fwd;
    wb_t       wb;
    redirect_t redirect;
    logic      hazard_stall;
    reg_idx_t  rs1_idx;
    reg_idx_t  rs2_idx;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     fetch_addr;
    word_t     fetch_word;
    logic      fetch_valid;
    logic      fetch_grant;

    fetch_control fetch_i (
        .clk          (clk),
        .reset        (reset),
        .fetch_grant  (fetch_grant),
        .fetch_word   (fetch_word),
        .hazard_stall (hazard_stall),
        .redirect     (redirect),
        .fetch_addr   (fetch_addr),
        .fetch_valid  (fetch_valid),
        .if_id        (if_id)
    );

    instr_decoder decoder_i (
        .clk          (clk),
        .reset        (reset),
        .if_id        (if_id),
        .redirect     (redirect),
        .rs1_idx      (rs1_idx),
        .rs2_idx      (rs2_idx),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .hazard_stall (hazard_stall),
        .id_ex        (id_ex)
    );

    register_file regfile_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    execute_unit execute_i (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex),
        .mem_fwd  (mem_fwd),
        .wb_fwd   (wb),
        .redirect (redirect),
        .ex_mem   (ex_mem)
    );

    memory_stage memory_i (
        .clk         (clk),
        .reset       (reset),
        .ex_mem      (ex_mem),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .fetch_grant (fetch_grant),
        .fetch_word  (fetch_word),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata),
        .mem_fwd     (mem_fwd),
        .wb          (wb)
    );

endmodule

// File: bench/rv_core_props.sv
`include "core_defines.svh"

module rv_core_props
    import pipe_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input mem_req_t  mem_req,
    input logic      fetch_grant,
    input word_t     fetch_addr,
    input redirect_t redirect
);

    // Store target reserved for branch shadows
    localparam word_t POISON_ADDR = 32'h0000_17fc;

    // Address the next granted fetch must use when no redirect intervenes
    word_t next_fetch;
    logic  next_known;

    always_ff @(posedge clk)
    begin
        if (reset || redirect.valid)
            next_known <= 1'b0;
        else if (fetch_grant)
        begin
            next_known <= 1'b1;
            next_fetch <= mem_req.addr + 32'd4;
        end
    end

    // ------------------------------------------------------------
    // Bus protocol
    // ------------------------------------------------------------
    reset_quiet: assert property (@(posedge clk)
        reset && $past(reset) |-> !mem_req.valid)
        else $error("bus request raised while reset is held");

    first_fetch: assert property (@(posedge clk)
        $fell(reset) |-> mem_req.valid && !mem_req.write && mem_req.addr == `CORE_RESET_PC)
        else $error("first request after reset is not a read of the reset PC");

    word_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid |-> mem_req.addr[1:0] == 2'b00)
        else $error("bus address is not word aligned");

    store_owns_bus: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid && mem_req.write && !redirect.valid |=> fetch_addr == $past(fetch_addr))
        else $error("fetch advanced in the same cycle as a store");

    // ------------------------------------------------------------
    // Control flow
    // ------------------------------------------------------------
    sequential_fetch: assert property (@(posedge clk) disable iff (reset)
        fetch_grant && next_known |-> mem_req.addr == next_fetch)
        else $error("fetch read did not advance by four from the previous fetch read");

    no_shadow_store: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid && mem_req.write |-> mem_req.addr != POISON_ADDR)
        else $error("store from a squashed branch shadow reached the bus");

endmodule

bind rv_core rv_core_props props_i (
    .clk         (clk),
    .reset       (reset),
    .mem_req     (mem_req),
    .fetch_grant (fetch_grant),
    .fetch_addr  (fetch_addr),
    .redirect    (redirect)
);

// File: bench/rv_core_tb.sv
module rv_core_tb
    import pipe_pkg::*;
    import isa_pkg::*;
();

    localparam int          MEM_WORDS    = 2048;
    localparam int          RESET_CYCLES = 8;
    localparam word_t       DATA_BASE    = 32'h0000_1000;
    localparam word_t       LOAD_ADDR    = 32'h0000_1100;
    localparam logic [11:0] POISON_OFF   = 12'h7fc;

    logic     clk;
    logic     reset;
    mem_req_t mem_req;
    word_t    mem_rdata;

    word_t       mem [MEM_WORDS];
    word_t       xr [32];
    word_t       exp_addr [$];
    word_t       exp_data [$];
    logic [31:0] lfsr;
    word_t       load_val;
    int          pc_words;
    int          value_errors;
    int          unexpected_stores;

    rv_core dut_i (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Memory model with combinational reads and writes at the edge
    // ------------------------------------------------------------
    assign mem_rdata = mem[mem_req.addr[12:2]];

    always @(posedge clk)
    begin
        if (mem_req.valid && mem_req.write)
            mem[mem_req.addr[12:2]] <= mem_req.wdata;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // RV32I integer semantics selected by funct3
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return word_t'($signed(a) < $signed(b));
            3'b011:  return word_t'(a < b);
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t next_pc();
        return word_t'(pc_words * 4);
    endfunction

    // ------------------------------------------------------------
    // Small assembler with a register model
    // ------------------------------------------------------------
    task automatic emit(input word_t instr);
        mem[pc_words] <= instr;
        pc_words++;
    endtask

    task automatic set_reg(input int rd, input word_t val);
        if (rd != 0)
            xr[rd] = val;
    endtask

    task automatic op_reg(input logic [2:0] f3, input logic alt, input int rd, rs1, rs2);
        emit({1'b0, alt, 5'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP});
        set_reg(rd, alu_ref(f3, alt, xr[rs1], xr[rs2]));
    endtask

    task automatic op_imm(input logic [2:0] f3, input int rd, rs1, input logic [11:0] imm);
        emit({imm, 5'(rs1), f3, 5'(rd), OPC_OP_IMM});
        set_reg(rd, alu_ref(f3, f3 == 3'b101 && imm[10], xr[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic upper(input logic is_auipc, input int rd, input logic [19:0] imm);
        set_reg(rd, {imm, 12'b0} + (is_auipc ? next_pc() : 32'd0));
        emit({imm, 5'(rd), is_auipc ? OPC_AUIPC : OPC_LUI});
    endtask

    // Word store relative to x31 that is expected unless it sits in a branch shadow
    task automatic store(input int rs2, input logic [11:0] off, input logic expected);
        emit({off[11:5], 5'(rs2), 5'd31, 3'b010, off[4:0], OPC_STORE});
        if (expected)
        begin
            exp_addr.push_back(DATA_BASE + {{20{off[11]}}, off});
            exp_data.push_back(xr[rs2]);
        end
    endtask

    task automatic load(input int rd, input logic [11:0] off, input word_t val);
        emit({off, 5'd31, 3'b010, 5'(rd), OPC_LOAD});
        set_reg(rd, val);
    endtask

    // Branch over one slot that holds a poison store when taken and a counter bump otherwise
    task automatic branch(input logic [2:0] f3, input int rs1, rs2);
        logic taken;
        taken = branch_ref(f3, xr[rs1], xr[rs2]);
        emit({7'b0, 5'(rs2), 5'(rs1), f3, 4'b0100, 1'b0, OPC_BRANCH});
        if (taken)
            store(1, POISON_OFF, 1'b0);
        else
            op_imm(3'b000, 18, 18, 12'd1);
    endtask

    task automatic build_program();
        upper(1'b0, 31, 20'h00001);
        // Dependent ALU chain
        upper(1'b0, 1, 20'(rand_bits(20)));
        op_imm(3'b000, 1, 1, 12'(rand_bits(12)));
        upper(1'b1, 2, 20'(rand_bits(20)));
        op_reg(3'b000, 1'b0, 3, 1, 2);
        op_reg(3'b000, 1'b1, 4, 3, 1);
        op_imm(3'b100, 5, 4, 12'(rand_bits(12)));
        op_imm(3'b001, 6, 5, {7'b0, 5'(rand_bits(5))});
        op_imm(3'b101, 7, 6, {7'b0100000, 5'(rand_bits(5))});
        op_imm(3'b101, 8, 6, {7'b0, 5'(rand_bits(5))});
        op_reg(3'b010, 1'b0, 9, 7, 8);
        op_reg(3'b011, 1'b0, 10, 7, 8);
        op_reg(3'b001, 1'b0, 11, 5, 3);
        op_reg(3'b101, 1'b1, 12, 7, 4);
        op_reg(3'b110, 1'b0, 9, 9, 11);
        op_reg(3'b111, 1'b0, 10, 10, 12);
        op_reg(3'b100, 1'b0, 11, 11, 8);
        op_reg(3'b101, 1'b0, 12, 12, 5);
        op_imm(3'b010, 2, 7, 12'(rand_bits(12)));
        op_imm(3'b011, 4, 5, 12'(rand_bits(12)));
        op_imm(3'b110, 6, 6, 12'(rand_bits(12)));
        op_imm(3'b111, 8, 8, 12'(rand_bits(12)));
        op_reg(3'b000, 1'b0, 2, 2, 4);
        for (int r = 1; r <= 12; r++)
            store(r, 12'(4 * (r - 1)), 1'b1);

        // Load-use into an add and then straight into store data
        load_val = rand_bits(32);
        mem[LOAD_ADDR[12:2]] <= load_val;
        load(13, 12'h100, load_val);
        op_reg(3'b000, 1'b0, 14, 13, 12);
        store(14, 12'h030, 1'b1);
        load(15, 12'h100, load_val);
        store(15, 12'h034, 1'b1);

        // Branch operands with x16 negative and x17 positive
        upper(1'b0, 16, 20'(rand_bits(20)) | 20'h80000);
        upper(1'b0, 17, (20'(rand_bits(20)) & 20'h7ffff) | 20'h00001);
        op_imm(3'b000, 18, 0, 12'd0);
        for (int f = 0; f < 8; f++)
        begin
            if (f != 2 && f != 3)
            begin
                branch(3'(f), 3, 3);
                branch(3'(f), 16, 17);
            end
        end

        // JAL over a poison store and then JALR to base plus 13
        set_reg(19, next_pc() + 32'd4);
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd19, OPC_JAL});
        store(1, POISON_OFF, 1'b0);
        upper(1'b1, 20, 20'd0);
        set_reg(21, next_pc() + 32'd4);
        emit({12'd13, 5'd20, 3'b000, 5'd21, OPC_JALR});
        store(1, POISON_OFF, 1'b0);
        for (int r = 18; r <= 21; r++)
            store(r, 12'(4 * (r - 4)), 1'b1);

        // Spin in place
        emit({20'd0, 5'd0, OPC_JAL});
    endtask

    // ------------------------------------------------------------
    // Store checks
    // ------------------------------------------------------------
    task automatic check_store(input word_t addr, input word_t data);
        word_t want_addr;
        word_t want_data;
        assert (exp_addr.size() != 0)
        else
        begin
            unexpected_stores++;
            $display("Unexpected store to %h with data %h", addr, data);
        end
        if (exp_addr.size() != 0)
        begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            assert (addr == want_addr)
            else
            begin
                value_errors++;
                $display("FAIL mem_req.addr got %h expected %h", addr, want_addr);
            end
            assert (data == want_data)
            else
            begin
                value_errors++;
                $display("FAIL mem_req.wdata got %h expected %h", data, want_data);
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (!reset && mem_req.valid && mem_req.write)
            check_store(mem_req.addr, mem_req.wdata);
    end

    task automatic print_summary();
        $display("Errors: %0d value mismatches, %0d unexpected stores, %0d missing stores",
                 value_errors, unexpected_stores, exp_addr.size());
    endtask

    initial
    begin
        clk               = 1'b0;
        reset             = 1'b1;
        lfsr              = 32'h08e6b16a;
        pc_words          = 0;
        value_errors      = 0;
        unexpected_stores = 0;
        for (int i = 0; i < 32; i++)
            xr[i] = '0;
        // Background fill that differs for every word
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] <= {~16'(i), 16'(i)};
        build_program();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (exp_addr.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);

        print_summary();
        if (value_errors + unexpected_stores + exp_addr.size() == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    // Watchdog sized from the assembled program length
    initial
    begin
        int limit;
        @(posedge clk);
        limit = pc_words * 40 + RESET_CYCLES;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles with %0d stores still pending",
                 limit, exp_addr.size());
        print_summary();
        $display("test failed");
        $finish;
    end

endmodule

// File: rv_core.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
decode/instr_decoder.sv
execute/execute_unit.sv
rtl/fetch_control.sv
rtl/register_file.sv
rtl/memory_stage.sv
rtl/rv_core.sv
bench/rv_core_props.sv
bench/rv_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
    -f rv_core.f \
    --top-module rv_core_tb \
    -Mdir "$BUILD_DIR" -o rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/rv_core_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
